/* bench/strip_trigger_input.txt */
# columns: hits_l0 hits_l1 hits_l2 hits_l3 hits_l4 hits_l5 min_layers exp_win exp_pri
# all hex, hit words carry strip n in bit n
00001 00001 00001 00001 00001 00001 3 0 6
00400 00400 00400 00400 00400 00400 3 8 6
20000 20000 20000 20000 20000 20000 3 f 6
00040 00080 00080 00100 00100 00200 3 6 5
00020 00020 04020 04020 04000 04000 3 3 4
00200 00200 00200 02000 02000 02000 3 7 3
00400 00400 00000 00000 00000 00000 3 0 0
00400 00400 00000 00000 00000 00000 2 8 2
02000 02000 00000 00000 20000 20000 2 b 2
10001 10001 10001 10000 10000 00000 2 e 5
00009 00009 00008 00008 00000 00000 2 1 4
00004 01004 01004 01000 01000 00000 4 a 4
00040 00080 00080 00100 00100 00200 4 6 5
00001 00001 00001 00001 00001 00001 6 0 6
00080 00080 00080 00080 00080 00000 6 0 0
00080 00080 00080 00080 00080 00000 5 5 5
00000 00000 00000 20000 00000 00000 1 f 1
00000 00000 00000 00000 00000 00000 1 0 0
00000 00000 00000 00000 00000 00000 0 0 0
3ffff 00000 00000 00000 00000 00000 1 0 1
3ffff 3ffff 3ffff 3ffff 3ffff 3ffff 3 0 6
00410 00410 00400 10000 10000 10000 3 8 3
3ffff 3ffff 3ffff 3ffff 3ffff 00000 3 0 5
08000 08000 08000 10000 10000 10000 3 e 6
00002 00004 00008 00010 00020 00040 3 1 3

/* strip_trigger.f */
design/strip_trigger_pkg.sv
design/window_scorer.sv
design/tree_encoder.sv
design/trig_regs_axil.sv
design/strip_trigger_top.sv
bench/strip_trigger_chk.sv
bench/strip_trigger_tb.sv

/* Makefile */
# Verilator build and run for the strip trigger testbench.

VERILATOR ?= verilator
TOP       ?= strip_trigger_tb
FILELIST  ?= strip_trigger.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := *** PASSED ***

SOURCES := $(wildcard design/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/strip_trigger_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module strip_trigger_tb
  import strip_trigger_pkg::*;
();

  localparam int    LAYERS     = 6;
  localparam int    MIN_RST    = 3;
  localparam string INPUT_FILE = "bench/strip_trigger_input.txt";

  logic        clk;
  logic        rst_n;
  strip_hits_t hits_l0;
  strip_hits_t hits_l1;
  strip_hits_t hits_l2;
  strip_hits_t hits_l3;
  strip_hits_t hits_l4;
  strip_hits_t hits_l5;
  logic        hit_valid;
  logic        best_valid;
  win_idx_t    best_win;
  win_pri_t    best_pri;
  axil_addr_t  awaddr;
  logic        awvalid;
  logic        awready;
  axil_data_t  wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  axil_addr_t  araddr;
  logic        arvalid;
  logic        arready;
  axil_data_t  rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  int         cycles        = 0;
  int         cycle_limit   = 2000;
  int         value_errors  = 0;   // main sequence.
  int         other_errors  = 0;
  int         result_errors = 0;   // result monitor.
  int         seq_errors    = 0;
  int         exp_due_q [$];       // cycle at which each result is due.
  win_idx_t   exp_win_q [$];
  win_pri_t   exp_pri_q [$];
  axil_data_t trig_expected = '0;
  win_idx_t   last_win      = '0;
  win_pri_t   last_pri      = '0;
  int         cur_min       = MIN_RST;

  strip_trigger_top #(
    .NUM_LAYERS     (LAYERS),
    .MIN_LAYERS_RST (MIN_RST)
  ) i_strip_trigger_top (.*);

  bind strip_trigger_top strip_trigger_chk i_strip_trigger_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .hit_valid  (hit_valid),
    .best_valid (best_valid),
    .best_pri   (best_pri),
    .min_layers (min_layers),
    .bvalid     (bvalid),
    .bready     (bready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // highest layer count wins, ties go to the lowest window.
  function automatic void best_window(input strip_hits_t h [LAYERS], input int min_l,
                                      output win_idx_t win, output win_pri_t pri);
    int cnt;
    int best_w;
    int best_cnt;
    best_w   = 0;
    best_cnt = 0;
    for (int w = 0; w < NUM_WIN; w++)
    begin
      cnt = 0;
      for (int l = 0; l < LAYERS; l++)
      begin
        if (h[l][w +: 3] != '0)
          cnt++;
      end
      if (cnt < min_l)
        cnt = 0;
      if (cnt > best_cnt)
      begin
        best_cnt = cnt;
        best_w   = w;
      end
    end
    win = win_idx_t'(best_w);
    pri = win_pri_t'(best_cnt);
  endfunction

  // called on a falling edge.
  task automatic apply_event(input strip_hits_t h [LAYERS], input win_idx_t win,
                             input win_pri_t pri);
    hits_l0   = h[0];
    hits_l1   = h[1];
    hits_l2   = h[2];
    hits_l3   = h[3];
    hits_l4   = h[4];
    hits_l5   = h[5];
    hit_valid = 1'b1;
    exp_due_q.push_back(cycles + 2);
    exp_win_q.push_back(win);
    exp_pri_q.push_back(pri);
    if (pri != '0)
      trig_expected = trig_expected + 1'b1;
    last_win = win;
    last_pri = pri;
  endtask

  task automatic wait_idle();
    while (exp_due_q.size() != 0)
      @(negedge clk);
  endtask

  task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
    assert (got == exp)
    else
    begin
      value_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready))
      @(negedge clk);
    @(negedge clk);                      // transfer on the edge just passed.
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (2) @(negedge clk);           // let bvalid wait a little.
    bready = 1'b1;
    while (!bvalid)
      @(negedge clk);
    check_data("bresp", axil_data_t'(bresp), axil_data_t'(AXIL_OKAY));
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, input int hold, output axil_data_t data);
    axil_data_t held;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready)
      @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    held    = rdata;
    repeat (hold)
    begin
      @(negedge clk);
      assert (rvalid)
      else
      begin
        other_errors++;
        $display("rvalid dropped while rready was low");
      end
      check_data("rdata", rdata, held);
    end
    rready = 1'b1;
    while (!rvalid)
      @(negedge clk);
    data = rdata;
    check_data("rresp", axil_data_t'(rresp), axil_data_t'(AXIL_OKAY));
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic set_min(input int min_l);
    axil_data_t rd;
    if (min_l != cur_min)
    begin
      axil_write(REG_MIN_LAYERS, axil_data_t'(min_l));
      axil_read(REG_MIN_LAYERS, 0, rd);
      check_data("rdata", rd, axil_data_t'(min_l));
      cur_min = min_l;
    end
  endtask

  // consecutive hit_valid cycles.
  task automatic random_burst(input int len);
    strip_hits_t h [LAYERS];
    logic [31:0] r0;
    logic [31:0] r1;
    win_idx_t    win;
    win_pri_t    pri;
    for (int i = 0; i < len; i++)
    begin
      for (int l = 0; l < LAYERS; l++)
      begin
        r0   = $urandom;
        r1   = $urandom;
        h[l] = r0[17:0] & r1[17:0];     // about one strip in four.
      end
      best_window(h, cur_min, win, pri);
      apply_event(h, win, pri);
      @(negedge clk);
    end
    hit_valid = 1'b0;
  endtask

  task automatic check_result();
    int       due;
    win_idx_t win;
    win_pri_t pri;
    due = exp_due_q.pop_front();
    win = exp_win_q.pop_front();
    pri = exp_pri_q.pop_front();
    assert (cycles == due)
    else
    begin
      seq_errors++;
      $display("result arrived at cycle %0d instead of cycle %0d", cycles, due);
    end
    assert (best_win == win)
    else
    begin
      result_errors++;
      $display("Fail best_win: got 0x%h, expected 0x%h", best_win, win);
    end
    assert (best_pri == pri)
    else
    begin
      result_errors++;
      $display("Fail best_pri: got 0x%h, expected 0x%h", best_pri, pri);
    end
  endtask

  // results are compared in event order.
  always @(negedge clk)
  begin
    if (rst_n && best_valid)
    begin
      if (exp_due_q.size() == 0)
      begin
        seq_errors++;
        $display("result published with no event pending");
      end
      else
        check_result();
    end
    else if (rst_n && exp_due_q.size() != 0 && cycles >= exp_due_q[0])
    begin
      seq_errors++;
      $display("no result for the event due at cycle %0d", exp_due_q[0]);
      void'(exp_due_q.pop_front());
      void'(exp_win_q.pop_front());
      void'(exp_pri_q.pop_front());
    end
  end

  initial
  begin
    int          fd;
    int          rc;
    int          chk_fails;
    string       line;
    string       lines_q [$];
    logic [31:0] f [9];
    strip_hits_t h [LAYERS];
    axil_data_t  rd;
    axil_data_t  count_before;
    rst_n     = 1'b0;
    hits_l0   = '0;
    hits_l1   = '0;
    hits_l2   = '0;
    hits_l3   = '0;
    hits_l4   = '0;
    hits_l5   = '0;
    hit_valid = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    rc        = $urandom(32'h28b4_54f2);

    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0)
    begin
      other_errors++;
      $display("cannot open %s", INPUT_FILE);
    end
    else
    begin
      while (!$feof(fd))
      begin
        rc = $fgets(line, fd);
        if (rc > 1 && line[0] != 8'h23)    // skip blanks and # lines.
          lines_q.push_back(line);
      end
      $fclose(fd);
    end
    cycle_limit = 40 * lines_q.size() + 2000;

    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    foreach (lines_q[i])
    begin
      rc = $sscanf(lines_q[i], "%h %h %h %h %h %h %h %h %h",
                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (rc != 9)
      begin
        other_errors++;
        $display("input line %0d could not be parsed", i + 1);
      end
      else
      begin
        set_min(int'(f[6]));
        for (int l = 0; l < LAYERS; l++)
          h[l] = f[l][17:0];
        apply_event(h, f[7][3:0], f[8][3:0]);
        @(negedge clk);
        hit_valid = 1'b0;
        wait_idle();
      end
    end

    for (int b = 0; b < 4; b++)
    begin
      random_burst(4 + int'($urandom % 5));
      wait_idle();
    end

    // stalled count read while hits keep coming.
    count_before = trig_expected;
    fork
      axil_read(REG_TRIG_COUNT, 6, rd);
      random_burst(6);
    join
    check_data("rdata", rd, count_before);
    wait_idle();

    axil_write(4'hc, 32'h5);                 // unmapped.
    axil_read(REG_MIN_LAYERS, 0, rd);
    check_data("rdata", rd, axil_data_t'(cur_min));
    axil_read(REG_TRIG_COUNT, 2, rd);
    check_data("rdata", rd, trig_expected);
    axil_read(REG_LAST_RESULT, 0, rd);
    check_data("rdata", rd, {24'd0, last_pri, last_win});
    axil_read(4'hc, 0, rd);
    check_data("rdata", rd, '0);
    repeat (2) @(negedge clk);

    chk_fails = i_strip_trigger_top.i_strip_trigger_chk.fail_count;
    $display("errors: %0d register, %0d result, %0d sequence, %0d protocol, %0d assertion",
             value_errors, result_errors, seq_errors, other_errors, chk_fails);
    if (value_errors + result_errors + seq_errors + other_errors + chk_fails == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/strip_trigger_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module strip_trigger_chk
  import strip_trigger_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       hit_valid,
  input logic       best_valid,
  input win_pri_t   best_pri,
  input win_pri_t   min_layers,
  input logic       bvalid,
  input logic       bready,
  input logic       rvalid,
  input logic       rready,
  input axil_data_t rdata
);

  int fail_count = 0;  // read back by the testbench.

  // fixed two edge latency of the hit path.
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    best_valid == $past(hit_valid, 2))
  else
  begin
    $error("best_valid does not follow hit_valid by two cycles");
    fail_count++;
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
  else
  begin
    $error("bvalid dropped before bready");
    fail_count++;
  end

  // rdata may not move while the response waits.
  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
  else
  begin
    $error("rvalid or rdata changed before rready");
    fail_count++;
  end

  // minimum applied one cycle before the result register.
  a_min_layers: assert property (@(posedge clk) disable iff (!rst_n)
    best_valid |-> (best_pri == '0 || best_pri >= $past(min_layers)))
  else
  begin
    $error("nonzero best_pri below the minimum layer count");
    fail_count++;
  end

endmodule

`default_nettype wire

/* design/strip_trigger_top.sv */
`timescale 1ns/1ns
`default_nettype none

module strip_trigger_top
  import strip_trigger_pkg::*;
#(
  parameter int NUM_LAYERS     = 6,
  parameter int MIN_LAYERS_RST = 3
)
(
  input  logic        clk,
  input  logic        rst_n,
  input  strip_hits_t hits_l0,
  input  strip_hits_t hits_l1,
  input  strip_hits_t hits_l2,
  input  strip_hits_t hits_l3,
  input  strip_hits_t hits_l4,
  input  strip_hits_t hits_l5,
  input  logic        hit_valid,
  output logic        best_valid,
  output win_idx_t    best_win,
  output win_pri_t    best_pri,
  input  axil_addr_t  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  axil_data_t  wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  axil_addr_t  araddr,
  input  logic        arvalid,
  output logic        arready,
  output axil_data_t  rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  localparam int NUM_PORTS = 6;

  strip_hits_t [NUM_PORTS-1:0]  port_hits;
  strip_hits_t [NUM_LAYERS-1:0] layer_hits;
  win_pri_t                     min_layers;
  logic                         score_valid;
  win_pri_t                     win_pri [NUM_WIN];
  win_idx_t                     win_best;
  win_pri_t                     pri_best;

  assign port_hits = {hits_l5, hits_l4, hits_l3, hits_l2, hits_l1, hits_l0};

  // layers beyond the six ports see no hits.
  for (genvar i = 0; i < NUM_LAYERS; i++)
  begin : g_layer
    if (i < NUM_PORTS)
    begin : g_port
      assign layer_hits[i] = port_hits[i];
    end
    else
    begin : g_none
      assign layer_hits[i] = '0;
    end
  end

  window_scorer #(
    .NUM_LAYERS (NUM_LAYERS)
  ) i_window_scorer (
    .clk         (clk),
    .rst_n       (rst_n),
    .hits        (layer_hits),
    .hit_valid   (hit_valid),
    .min_layers  (min_layers),
    .score_valid (score_valid),
    .win_pri_0   (win_pri[0]),
    .win_pri_1   (win_pri[1]),
    .win_pri_2   (win_pri[2]),
    .win_pri_3   (win_pri[3]),
    .win_pri_4   (win_pri[4]),
    .win_pri_5   (win_pri[5]),
    .win_pri_6   (win_pri[6]),
    .win_pri_7   (win_pri[7]),
    .win_pri_8   (win_pri[8]),
    .win_pri_9   (win_pri[9]),
    .win_pri_10  (win_pri[10]),
    .win_pri_11  (win_pri[11]),
    .win_pri_12  (win_pri[12]),
    .win_pri_13  (win_pri[13]),
    .win_pri_14  (win_pri[14]),
    .win_pri_15  (win_pri[15])
  );

  tree_encoder i_tree_encoder (
    .win_pri_0  (win_pri[0]),
    .win_pri_1  (win_pri[1]),
    .win_pri_2  (win_pri[2]),
    .win_pri_3  (win_pri[3]),
    .win_pri_4  (win_pri[4]),
    .win_pri_5  (win_pri[5]),
    .win_pri_6  (win_pri[6]),
    .win_pri_7  (win_pri[7]),
    .win_pri_8  (win_pri[8]),
    .win_pri_9  (win_pri[9]),
    .win_pri_10 (win_pri[10]),
    .win_pri_11 (win_pri[11]),
    .win_pri_12 (win_pri[12]),
    .win_pri_13 (win_pri[13]),
    .win_pri_14 (win_pri[14]),
    .win_pri_15 (win_pri[15]),
    .win_best   (win_best),
    .pri_best   (pri_best)
  );

  // result register, second edge of the hit path.
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      best_valid <= 1'b0;
    else
      best_valid <= score_valid;
  end

  always_ff @(posedge clk)
  begin
    if (score_valid)
    begin
      best_win <= win_best;
      best_pri <= pri_best;
    end
  end

  trig_regs_axil #(
    .MIN_LAYERS_RST (MIN_LAYERS_RST)
  ) i_trig_regs_axil (
    .clk        (clk),
    .rst_n      (rst_n),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .best_valid (best_valid),
    .best_win   (best_win),
    .best_pri   (best_pri),
    .min_layers (min_layers)
  );

endmodule

`default_nettype wire

/* design/trig_regs_axil.sv */
`timescale 1ns/1ns
`default_nettype none

module trig_regs_axil
  import strip_trigger_pkg::*;
#(
  parameter int MIN_LAYERS_RST = 3
)
(
  input  logic       clk,
  input  logic       rst_n,
  // write address and data.
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  logic [3:0] wstrb,
  input  logic       wvalid,
  output logic       wready,
  // write response.
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  // read.
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output axil_data_t rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,
  // trigger result.
  input  logic       best_valid,
  input  win_idx_t   best_win,
  input  win_pri_t   best_pri,
  output win_pri_t   min_layers
);

  typedef enum logic {W_IDLE, W_RESP} wr_state_t;
  typedef enum logic {R_IDLE, R_DATA} rd_state_t;

  wr_state_t  wr_state;
  rd_state_t  rd_state;
  logic       wr_fire;
  logic       rd_fire;
  win_pri_t   min_layers_q;
  axil_data_t trig_count;
  logic [7:0] last_result;    // {pri, window}.
  axil_data_t rd_mux;

  assign wr_fire = awvalid && awready && wvalid && wready;
  assign rd_fire = arvalid && arready;

  // write channel.
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_state     <= W_IDLE;
      awready      <= 1'b0;
      wready       <= 1'b0;
      bvalid       <= 1'b0;
      min_layers_q <= win_pri_t'(MIN_LAYERS_RST);
    end
    else
    begin
      case (wr_state)
        W_IDLE:
        begin
          if (awready)
          begin
            awready <= 1'b0;                 // one cycle only.
            wready  <= 1'b0;
            if (wr_fire)
            begin
              if (awaddr == REG_MIN_LAYERS && wstrb[0])
                min_layers_q <= wdata[3:0];
              bvalid   <= 1'b1;
              wr_state <= W_RESP;
            end
          end
          else if (awvalid && wvalid)
          begin
            awready <= 1'b1;
            wready  <= 1'b1;
          end
        end
        W_RESP:
        begin
          if (bready)
          begin
            bvalid   <= 1'b0;
            wr_state <= W_IDLE;
          end
        end
        default: wr_state <= W_IDLE;
      endcase
    end
  end

  // read decode, unmapped reads zero.
  always_comb
  begin
    case (araddr)
      REG_MIN_LAYERS:  rd_mux = {28'd0, min_layers_q};
      REG_TRIG_COUNT:  rd_mux = trig_count;
      REG_LAST_RESULT: rd_mux = {24'd0, last_result};
      default:         rd_mux = '0;
    endcase
  end

  // read channel.
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rd_state <= R_IDLE;
      arready  <= 1'b0;
      rvalid   <= 1'b0;
    end
    else
    begin
      case (rd_state)
        R_IDLE:
        begin
          if (arready)
          begin
            arready <= 1'b0;
            if (rd_fire)
            begin
              rvalid   <= 1'b1;
              rd_state <= R_DATA;
            end
          end
          else if (arvalid)
            arready <= 1'b1;
        end
        R_DATA:
        begin
          if (rready)
          begin
            rvalid   <= 1'b0;
            rd_state <= R_IDLE;
          end
        end
        default: rd_state <= R_IDLE;
      endcase
    end
  end

  // held stable while rvalid waits.
  always_ff @(posedge clk)
  begin
    if (rd_fire)
      rdata <= rd_mux;
  end

  // trigger statistics.
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      trig_count  <= '0;
      last_result <= '0;
    end
    else if (best_valid)
    begin
      last_result <= {best_pri, best_win};
      if (best_pri != '0)
        trig_count <= trig_count + 1'b1;   // nonzero results only.
    end
  end

  assign bresp      = AXIL_OKAY;
  assign rresp      = AXIL_OKAY;
  assign min_layers = min_layers_q;

endmodule

`default_nettype wire

/* design/tree_encoder.sv */
`timescale 1ns/1ns
`default_nettype none

module tree_encoder
  import strip_trigger_pkg::*;
(
  input  win_pri_t win_pri_0,
  input  win_pri_t win_pri_1,
  input  win_pri_t win_pri_2,
  input  win_pri_t win_pri_3,
  input  win_pri_t win_pri_4,
  input  win_pri_t win_pri_5,
  input  win_pri_t win_pri_6,
  input  win_pri_t win_pri_7,
  input  win_pri_t win_pri_8,
  input  win_pri_t win_pri_9,
  input  win_pri_t win_pri_10,
  input  win_pri_t win_pri_11,
  input  win_pri_t win_pri_12,
  input  win_pri_t win_pri_13,
  input  win_pri_t win_pri_14,
  input  win_pri_t win_pri_15,
  output win_idx_t win_best,
  output win_pri_t pri_best
);

  win_pri_t    pri_in [NUM_WIN];
  win_pri_t    pri_s0 [8];
  logic        win_s0 [8];       // index within pair.
  win_pri_t    pri_s1 [4];
  logic [1:0]  win_s1 [4];       // index within quad.
  win_pri_t    pri_s2;
  win_idx_t    win_s2;

  assign pri_in = '{win_pri_0,  win_pri_1,  win_pri_2,  win_pri_3,
                    win_pri_4,  win_pri_5,  win_pri_6,  win_pri_7,
                    win_pri_8,  win_pri_9,  win_pri_10, win_pri_11,
                    win_pri_12, win_pri_13, win_pri_14, win_pri_15};

  // pairwise level, upper index only on a strict win.
  for (genvar p = 0; p < 8; p++)
  begin : g_s0
    assign {pri_s0[p], win_s0[p]} = (pri_in[2*p+1] > pri_in[2*p]) ?
                                    {pri_in[2*p+1], 1'b1} : {pri_in[2*p], 1'b0};
  end

  // best of four.
  for (genvar q = 0; q < 4; q++)
  begin : g_s1
    assign {pri_s1[q], win_s1[q]} = (pri_s0[2*q+1] > pri_s0[2*q]) ?
                                    {pri_s0[2*q+1], 1'b1, win_s0[2*q+1]} :
                                    {pri_s0[2*q],   1'b0, win_s0[2*q]};
  end

  // 1-of-4 parallel stage, a quad must beat every lower one.
  always_comb
  begin
    if ((pri_s1[3] > pri_s1[2]) && (pri_s1[3] > pri_s1[1]) && (pri_s1[3] > pri_s1[0]))
    begin
      pri_s2 = pri_s1[3];
      win_s2 = {2'd3, win_s1[3]};
    end
    else if ((pri_s1[2] > pri_s1[1]) && (pri_s1[2] > pri_s1[0]))
    begin
      pri_s2 = pri_s1[2];
      win_s2 = {2'd2, win_s1[2]};
    end
    else if (pri_s1[1] > pri_s1[0])
    begin
      pri_s2 = pri_s1[1];
      win_s2 = {2'd1, win_s1[1]};
    end
    else
    begin
      pri_s2 = pri_s1[0];
      win_s2 = {2'd0, win_s1[0]};
    end
  end

  assign win_best = win_s2;
  assign pri_best = pri_s2;

endmodule

`default_nettype wire

/* design/window_scorer.sv */
`timescale 1ns/1ns
`default_nettype none

module window_scorer
  import strip_trigger_pkg::*;
#(
  parameter int NUM_LAYERS = 6
)
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  strip_hits_t [NUM_LAYERS-1:0] hits,
  input  logic                         hit_valid,
  input  win_pri_t                     min_layers,
  output logic                         score_valid,
  output win_pri_t                     win_pri_0,
  output win_pri_t                     win_pri_1,
  output win_pri_t                     win_pri_2,
  output win_pri_t                     win_pri_3,
  output win_pri_t                     win_pri_4,
  output win_pri_t                     win_pri_5,
  output win_pri_t                     win_pri_6,
  output win_pri_t                     win_pri_7,
  output win_pri_t                     win_pri_8,
  output win_pri_t                     win_pri_9,
  output win_pri_t                     win_pri_10,
  output win_pri_t                     win_pri_11,
  output win_pri_t                     win_pri_12,
  output win_pri_t                     win_pri_13,
  output win_pri_t                     win_pri_14,
  output win_pri_t                     win_pri_15
);

  strip_hits_t [NUM_LAYERS-1:0] hits_q;    // captured event.
  win_pri_t                     layer_cnt [NUM_WIN];
  win_pri_t                     pri       [NUM_WIN];

  // stage 1 valid.
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      score_valid <= 1'b0;
    else
      score_valid <= hit_valid;
  end

  always_ff @(posedge clk)
  begin
    if (hit_valid)
      hits_q <= hits;
  end

  // count layers with any hit inside each window.
  for (genvar w = 0; w < NUM_WIN; w++)
  begin : g_win
    always_comb
    begin
      layer_cnt[w] = '0;
      for (int l = 0; l < NUM_LAYERS; l++)
      begin
        if (|hits_q[l][w +: 3])
          layer_cnt[w] = layer_cnt[w] + 1'b1;
      end
    end

    assign pri[w] = (layer_cnt[w] < min_layers) ? '0 : layer_cnt[w];  // below threshold.
  end

  assign win_pri_0  = pri[0];
  assign win_pri_1  = pri[1];
  assign win_pri_2  = pri[2];
  assign win_pri_3  = pri[3];
  assign win_pri_4  = pri[4];
  assign win_pri_5  = pri[5];
  assign win_pri_6  = pri[6];
  assign win_pri_7  = pri[7];
  assign win_pri_8  = pri[8];
  assign win_pri_9  = pri[9];
  assign win_pri_10 = pri[10];
  assign win_pri_11 = pri[11];
  assign win_pri_12 = pri[12];
  assign win_pri_13 = pri[13];
  assign win_pri_14 = pri[14];
  assign win_pri_15 = pri[15];

endmodule

`default_nettype wire

/* design/strip_trigger_pkg.sv */
`default_nettype none

package strip_trigger_pkg;

  // window geometry.
  localparam int NUM_WIN    = 16;           // the encoder tree is built for 16.
  localparam int NUM_STRIPS = NUM_WIN + 2;  // three-strip windows overlap by two.

  // one layer of strip hits, bit index is the strip number.
  typedef logic [NUM_STRIPS-1:0] strip_hits_t;

  // layer count of a window, or zero when below the minimum.
  typedef logic [3:0] win_pri_t;

  // window k covers strips k, k+1 and k+2.
  typedef logic [3:0] win_idx_t;

  // register bus.
  typedef logic [3:0]  axil_addr_t;         // byte address.
  typedef logic [31:0] axil_data_t;

  // register map.
  localparam axil_addr_t REG_MIN_LAYERS  = 4'h0;  // rw, low 4 bits.
  localparam axil_addr_t REG_TRIG_COUNT  = 4'h4;  // ro, 32-bit count.
  localparam axil_addr_t REG_LAST_RESULT = 4'h8;  // ro, pri in 7:4, window in 3:0.

  localparam logic [1:0] AXIL_OKAY = 2'b00;

endpackage

`default_nettype wire
